//--- lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    // basic widths for an rv32 core
    typedef logic [31:0] addr_t;  // byte address
    typedef logic [31:0] data_t;  // register value or store datum
    typedef logic [31:0] inst_t;  // raw instruction word

    // access size, encoded the same way as funct3[1:0] of a store
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_t;

    // one store queue entry
    // issued goes high once the store has its address and data
    // fault marks a store that must never reach memory
    typedef struct packed {
        logic      issued;
        logic      fault;
        mem_size_t size;
        addr_t     target_addr;
        data_t     store_data;
    } store_entry_t;

    // legal funct3 codes of the store opcode
    localparam logic [2:0] funct3_sb = 3'b000;
    localparam logic [2:0] funct3_sh = 3'b001;
    localparam logic [2:0] funct3_sw = 3'b010;

    // anything above sw in funct3 has no meaning for a store
    // sd would be 3'b011 on rv64, which this core does not support

endpackage

`default_nettype wire

//--- store_decode.sv
`default_nettype none

module store_decode import lsq_pkg::*; (
    input  inst_t     issue_inst,       // store instruction from the issue packet
    output mem_size_t decoded_size,     // access size from funct3
    output data_t     decoded_imm,      // sign extended S-type immediate
    output logic      decoded_illegal   // funct3 is not a legal store size
);

    logic [2:0] funct3;

    assign funct3 = issue_inst[14:12];

    // S-type immediate is split into imm[11:5] at 31:25 and imm[4:0] at 11:7
    assign decoded_imm = {{20{issue_inst[31]}}, issue_inst[31:25], issue_inst[11:7]};

    always_comb begin
        decoded_illegal = 1'b0;
        case (funct3)
            funct3_sb: begin
                decoded_size = size_byte;
            end
            funct3_sh: begin
                decoded_size = size_half;
            end
            funct3_sw: begin
                decoded_size = size_word;
            end
            default: begin
                // size is a don't care here, the fault bit keeps the store out of memory
                decoded_size    = size_word;
                decoded_illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- store_address_unit.sv
`default_nettype none

module store_address_unit import lsq_pkg::*; (
    input  logic         issue_valid,      // issue strobe for this cycle
    input  data_t        issue_base,       // rs1 value
    input  data_t        issue_value,      // rs2 value, the data to store
    input  mem_size_t    decoded_size,
    input  data_t        decoded_imm,
    input  logic         decoded_illegal,
    output store_entry_t entry_write       // entry written into the queue at the issue index
);

    addr_t effective_addr;
    logic  misaligned;
    data_t masked_data;

    assign effective_addr = issue_base + decoded_imm;  // wraps at 2^32 like the ISA says

    // a half must sit on an even address and a word on a multiple of four
    always_comb begin
        case (decoded_size)
            size_half: misaligned = effective_addr[0];
            size_word: misaligned = |effective_addr[1:0];
            default:   misaligned = 1'b0;  // bytes are always aligned
        endcase
    end

    // only the low bytes of rs2 are stored, the upper ones are cleared
    always_comb begin
        case (decoded_size)
            size_byte: masked_data = {24'b0, issue_value[7:0]};
            size_half: masked_data = {16'b0, issue_value[15:0]};
            default:   masked_data = issue_value;
        endcase
    end

    always_comb begin
        entry_write.issued      = issue_valid;
        entry_write.fault       = decoded_illegal | misaligned;  // either one blocks the store
        entry_write.size        = decoded_size;
        entry_write.target_addr = effective_addr;
        entry_write.store_data  = masked_data;
    end

endmodule

`default_nettype wire

//--- store_queue.sv
`default_nettype none

module store_queue import lsq_pkg::*; #(
    parameter int DEPTH          = 8,  // number of entries, a power of two
    parameter int DISPATCH_WIDTH = 2   // most stores dispatched in one cycle
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0] num_store_dispatched,
    input  logic                                issue_valid,
    input  logic [$clog2(DEPTH)-1:0]            issue_index,   // entry saved at dispatch
    input  store_entry_t                        entry_write,
    input  logic                                retire_store,  // frees the head entry
    input  logic                                branch_recover,
    input  logic [$clog2(DEPTH)-1:0]            recover_tail,  // tail after the rollback
    output store_entry_t                        head_entry,
    output logic [$clog2(DEPTH)-1:0]            sq_head,
    output logic [$clog2(DEPTH)-1:0]            sq_tail,
    output logic                                sq_full,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0] open_entries
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int DSP_W = $clog2(DISPATCH_WIDTH + 1);

    store_entry_t [DEPTH-1:0] entries;

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;   // one past the youngest allocated entry
    logic [CNT_W-1:0] count;  // allocated entries, issued or not

    logic [IDX_W-1:0] next_tail;
    logic [CNT_W-1:0] next_count;
    logic [IDX_W-1:0] rollback;     // entries removed by a branch recovery
    logic [CNT_W-1:0] free_slots;
    logic [DEPTH-1:0] squash_mask;  // entries dropped by the recovery this cycle

    // DEPTH is a power of two, so index arithmetic wraps on its own
    assign rollback = branch_recover ? (tail - recover_tail) : '0;

    always_comb begin
        logic [IDX_W-1:0] offset;

        // everything from recover_tail up to the old tail belongs to a wrong path
        for (int i = 0; i < DEPTH; i++) begin
            offset         = IDX_W'(i) - recover_tail;
            squash_mask[i] = branch_recover && (offset < rollback);
        end
    end

    always_comb begin
        // new stores are placed after the rolled back tail
        next_tail  = (branch_recover ? recover_tail : tail) + IDX_W'(num_store_dispatched);
        next_count = count - CNT_W'(rollback) + CNT_W'(num_store_dispatched);
        if (retire_store) begin
            next_count = next_count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            entries <= '0;
        end else begin
            tail  <= next_tail;
            count <= next_count;
            if (retire_store) begin
                head <= head + 1'b1;  // wraps at DEPTH
            end
            for (int i = 0; i < DEPTH; i++) begin
                if (squash_mask[i] || (retire_store && IDX_W'(i) == head)) begin
                    entries[i] <= '0;
                end
            end
            // a store killed by the recovery in the same cycle must not come back to life
            if (issue_valid && !squash_mask[issue_index]) begin
                entries[issue_index] <= entry_write;
            end
        end
    end

    assign head_entry = entries[head];  // seen by the commit stage without delay

    assign sq_head = head;
    assign sq_tail = tail;
    assign sq_full = (count == CNT_W'(DEPTH));

    assign free_slots = CNT_W'(DEPTH) - count;

    // dispatch never asks for more than one cycle's worth of slots
    always_comb begin
        if (int'(free_slots) > DISPATCH_WIDTH) begin
            open_entries = DSP_W'(DISPATCH_WIDTH);
        end else begin
            open_entries = DSP_W'(free_slots);
        end
    end

endmodule

`default_nettype wire

//--- store_commit.sv
`default_nettype none

module store_commit import lsq_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         retire_store,      // reorder buffer retires the head store
    input  store_entry_t head_entry,
    input  logic         dmem_store_done,   // memory has finished the write
    output logic         dmem_store_valid,  // one cycle request strobe
    output addr_t        dmem_addr,
    output data_t        dmem_data,
    output mem_size_t    dmem_size,
    output logic         store_busy,        // blocks further retirement
    output logic         store_fault        // one cycle strobe for a faulting store
);

    logic  good_retire;
    logic  bad_retire;
    addr_t req_addr;
    data_t req_data;
    mem_size_t req_size;

    assign good_retire = retire_store & ~head_entry.fault;
    assign bad_retire  = retire_store &  head_entry.fault;

    // request payload is captured only for stores that go to memory
    // and stays put until the next good retire, so it is stable while busy
    always_ff @(posedge clock) begin
        if (good_retire) begin
            req_addr <= head_entry.target_addr;
            req_data <= head_entry.store_data;
            req_size <= head_entry.size;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dmem_store_valid <= 1'b0;
            store_fault      <= 1'b0;
            store_busy       <= 1'b0;
        end else begin
            dmem_store_valid <= good_retire;  // high for exactly the cycle after retire
            store_fault      <= bad_retire;   // a faulting store never raises busy
            if (good_retire) begin
                store_busy <= 1'b1;
            end else if (dmem_store_done) begin
                store_busy <= 1'b0;  // falls in the cycle after done
            end
        end
    end

    assign dmem_addr = req_addr;
    assign dmem_data = req_data;
    assign dmem_size = req_size;

endmodule

`default_nettype wire

//--- store_subsystem.sv
`default_nettype none

module store_subsystem import lsq_pkg::*; #(
    parameter int DEPTH          = 8,
    parameter int DISPATCH_WIDTH = 2
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0] num_store_dispatched,
    input  logic                                issue_valid,
    input  logic [$clog2(DEPTH)-1:0]            issue_index,
    input  inst_t                               issue_inst,
    input  data_t                               issue_base,
    input  data_t                               issue_value,
    input  logic                                branch_recover,
    input  logic [$clog2(DEPTH)-1:0]            recover_tail,
    input  logic                                retire_store,
    input  logic                                dmem_store_done,
    output logic [$clog2(DEPTH)-1:0]            sq_head,
    output logic [$clog2(DEPTH)-1:0]            sq_tail,
    output logic                                sq_full,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0] open_entries,
    output logic                                dmem_store_valid,
    output addr_t                               dmem_addr,
    output data_t                               dmem_data,
    output mem_size_t                           dmem_size,
    output logic                                store_busy,
    output logic                                store_fault
);

    mem_size_t    decoded_size;
    data_t        decoded_imm;
    logic         decoded_illegal;
    store_entry_t entry_write;  // decode and execute result, written at the issue edge
    store_entry_t head_entry;   // oldest store, read by commit

    store_decode i_store_decode (
        .issue_inst      (issue_inst),
        .decoded_size    (decoded_size),
        .decoded_imm     (decoded_imm),
        .decoded_illegal (decoded_illegal)
    );

    store_address_unit i_store_address_unit (
        .issue_valid     (issue_valid),
        .issue_base      (issue_base),
        .issue_value     (issue_value),
        .decoded_size    (decoded_size),
        .decoded_imm     (decoded_imm),
        .decoded_illegal (decoded_illegal),
        .entry_write     (entry_write)
    );

    store_queue #(
        .DEPTH          (DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) i_store_queue (
        .clock                (clock),
        .reset                (reset),
        .num_store_dispatched (num_store_dispatched),
        .issue_valid          (issue_valid),
        .issue_index          (issue_index),
        .entry_write          (entry_write),
        .retire_store         (retire_store),
        .branch_recover       (branch_recover),
        .recover_tail         (recover_tail),
        .head_entry           (head_entry),
        .sq_head              (sq_head),
        .sq_tail              (sq_tail),
        .sq_full              (sq_full),
        .open_entries         (open_entries)
    );

    // retire_store reaches both the queue and commit in the same cycle
    store_commit i_store_commit (
        .clock            (clock),
        .reset            (reset),
        .retire_store     (retire_store),
        .head_entry       (head_entry),
        .dmem_store_done  (dmem_store_done),
        .dmem_store_valid (dmem_store_valid),
        .dmem_addr        (dmem_addr),
        .dmem_data        (dmem_data),
        .dmem_size        (dmem_size),
        .store_busy       (store_busy),
        .store_fault      (store_fault)
    );

endmodule

`default_nettype wire

//--- store_subsystem_tb.sv
`default_nettype none

module store_subsystem_tb import lsq_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH          = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int MAX_CYCLES     = 2000;  // the six tests need a few hundred cycles at most

    logic       clock;
    logic       reset;
    logic [1:0] num_store_dispatched;
    logic       issue_valid;
    logic [2:0] issue_index;
    inst_t      issue_inst;
    data_t      issue_base;
    data_t      issue_value;
    logic       branch_recover;
    logic [2:0] recover_tail;
    logic       retire_store;
    logic       dmem_store_done;
    logic [2:0] sq_head;
    logic [2:0] sq_tail;
    logic       sq_full;
    logic [1:0] open_entries;
    logic       dmem_store_valid;
    addr_t      dmem_addr;
    data_t      dmem_data;
    mem_size_t  dmem_size;
    logic       store_busy;
    logic       store_fault;

    // expected contents of each queue index, filled in when a store issues
    addr_t     exp_addr  [DEPTH];
    data_t     exp_data  [DEPTH];
    mem_size_t exp_size  [DEPTH];
    logic      exp_fault [DEPTH];

    int     errors      = 0;
    int     passes      = 0;
    int     cycle_count = 0;
    int     mem_delay;
    integer seed        = 8;  // fixed seed for the memory latency

    store_subsystem #(
        .DEPTH          (DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) i_store_subsystem (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    // memory answers every request with done after 1 to 6 cycles
    always begin
        @(negedge clock);
        if (dmem_store_valid) begin
            mem_delay = 1 + int'($unsigned($random(seed)) % 6);
            repeat (mem_delay) @(negedge clock);
            dmem_store_done = 1'b1;
            @(negedge clock);
            dmem_store_done = 1'b0;
        end
    end

    task automatic log_check(input logic ok, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (ok) begin
            passes++;
        end else begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        log_check(got === exp, name, got, exp);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        log_check(got === exp, name, got, exp);
    endtask

    task automatic check_size(input string name, input mem_size_t got, input mem_size_t exp);
        log_check(got === exp, name, got, exp);
    endtask

    task automatic check_index(input string name, input logic [3:0] got, input logic [3:0] exp);
        log_check(got === exp, name, got, exp);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        log_check(got === exp, name, got, exp);
    endtask

    task automatic report_test(input string name, input int start);
        $display("%-20s done, %0d errors", name, errors - start);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(negedge clock);
        reset = 1'b0;
    endtask

    // S-type store with rs1 = x1 and rs2 = x2
    function automatic inst_t make_store(input logic [2:0] funct3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, funct3, imm[4:0], 7'b0100011};
    endfunction

    task automatic dispatch(input logic [1:0] n);
        num_store_dispatched = n;  // tail moves at the next edge
        @(negedge clock);
        num_store_dispatched = 2'd0;
    endtask

    task automatic issue_store(input logic [2:0] idx, input logic [2:0] funct3,
                               input logic [11:0] imm, input data_t base, input data_t value);
        addr_t addr;
        addr = base + {{20{imm[11]}}, imm};  // the immediate is sign extended
        exp_addr[idx] = addr;
        case (funct3)
            funct3_sb: begin
                exp_size[idx] = size_byte;
                exp_data[idx] = {24'h0, value[7:0]};
            end
            funct3_sh: begin
                exp_size[idx] = size_half;
                exp_data[idx] = {16'h0, value[15:0]};
            end
            default: begin
                exp_size[idx] = size_word;
                exp_data[idx] = value;
            end
        endcase
        exp_fault[idx] = (funct3 > funct3_sw) || (funct3 == funct3_sh && addr[0]) ||
                         (funct3 == funct3_sw && addr[1:0] != 2'b00);
        issue_valid = 1'b1;
        issue_index = idx;
        issue_inst  = make_store(funct3, imm);
        issue_base  = base;
        issue_value = value;
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    // retires the head and checks the request or fault in the following cycle
    task automatic retire_check(input logic [2:0] idx);
        logic done_seen;
        check_index("sq_head", sq_head, idx);
        retire_store = 1'b1;
        @(negedge clock);
        retire_store = 1'b0;
        check_flag("store_fault", store_fault, exp_fault[idx]);
        check_flag("dmem_store_valid", dmem_store_valid, !exp_fault[idx]);
        check_flag("store_busy", store_busy, !exp_fault[idx]);
        if (!exp_fault[idx]) begin
            check_addr("dmem_addr", dmem_addr, exp_addr[idx]);
            check_data("dmem_data", dmem_data, exp_data[idx]);
            check_size("dmem_size", dmem_size, exp_size[idx]);
        end
        @(negedge clock);
        check_flag("dmem_store_valid", dmem_store_valid, 1'b0);  // both are single cycle strobes
        check_flag("store_fault", store_fault, 1'b0);
        // busy holds until memory reports done and drops in the cycle after it
        done_seen = exp_fault[idx];
        while (!done_seen) begin
            @(posedge clock);
            done_seen = dmem_store_done;  // done only changes on falling edges
            @(negedge clock);
            check_flag("store_busy", store_busy, !done_seen);
        end
    endtask

    task automatic reset_state();
        int start;
        start = errors;
        apply_reset();
        check_index("sq_head", sq_head, 4'd0);
        check_index("sq_tail", sq_tail, 4'd0);
        check_flag("sq_full", sq_full, 1'b0);
        check_index("open_entries", open_entries, 4'd2);
        check_flag("dmem_store_valid", dmem_store_valid, 1'b0);
        check_flag("store_busy", store_busy, 1'b0);
        check_flag("store_fault", store_fault, 1'b0);
        report_test("reset state", start);
    endtask

    task automatic in_order_stores();
        int start;
        start = errors;
        apply_reset();
        dispatch(2'd2);
        dispatch(2'd1);
        check_index("sq_tail", sq_tail, 4'd3);
        issue_store(3'd0, funct3_sb, 12'h005, 32'h0000_1000, 32'hdead_beef);
        issue_store(3'd1, funct3_sh, 12'hffe, 32'h0000_2002, 32'h1234_5678);  // offset of -2
        issue_store(3'd2, funct3_sw, 12'h010, 32'h0000_3000, 32'hcafe_f00d);
        for (int i = 0; i < 3; i++) begin
            retire_check(3'(i));
        end
        check_index("sq_head", sq_head, 4'd3);
        report_test("in-order stores", start);
    endtask

    task automatic out_of_order_issue();
        int start;
        start = errors;
        apply_reset();
        dispatch(2'd2);
        dispatch(2'd2);
        for (int i = 3; i >= 0; i--) begin
            issue_store(3'(i), funct3_sw, 12'(4 * i), 32'h0000_8000, 32'h1111_0000 | data_t'(i));
        end
        // memory must still see index 0 first
        for (int i = 0; i < 4; i++) begin
            retire_check(3'(i));
        end
        report_test("out-of-order issue", start);
    endtask

    task automatic queue_capacity();
        int start;
        start = errors;
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            check_index("open_entries", open_entries, 4'd2);
            dispatch(2'd2);
        end
        check_index("open_entries", open_entries, 4'd0);
        check_flag("sq_full", sq_full, 1'b1);
        check_index("sq_tail", sq_tail, 4'd0);  // tail wrapped back to the head
        issue_store(3'd0, funct3_sh, 12'h002, 32'h0000_4000, 32'habcd_1234);
        retire_check(3'd0);
        check_index("open_entries", open_entries, 4'd1);
        check_flag("sq_full", sq_full, 1'b0);
        report_test("capacity", start);
    endtask

    task automatic branch_rollback();
        int start;
        start = errors;
        apply_reset();
        dispatch(2'd2);
        dispatch(2'd2);
        dispatch(2'd1);
        check_index("sq_tail", sq_tail, 4'd5);
        branch_recover = 1'b1;
        recover_tail   = 3'd2;  // only the first two stores survive
        @(negedge clock);
        branch_recover = 1'b0;
        check_index("sq_tail", sq_tail, 4'd2);
        check_index("open_entries", open_entries, 4'd2);
        dispatch(2'd1);
        check_index("sq_tail", sq_tail, 4'd3);  // index 2 handed out again
        dispatch(2'd2);
        dispatch(2'd2);
        check_index("open_entries", open_entries, 4'd1);  // seven allocated after the rollback
        issue_store(3'd0, funct3_sw, 12'h000, 32'h0000_7000, 32'h7070_0000);
        issue_store(3'd1, funct3_sb, 12'h001, 32'h0000_7000, 32'h7070_0071);
        issue_store(3'd2, funct3_sh, 12'h006, 32'h0000_7000, 32'h7070_7272);
        for (int i = 0; i < 3; i++) begin
            retire_check(3'(i));
        end
        report_test("branch recovery", start);
    endtask

    task automatic fault_stores();
        int start;
        start = errors;
        apply_reset();
        dispatch(2'd2);
        issue_store(3'd0, 3'd3, 12'h000, 32'h0000_5000, 32'h5555_5555);       // illegal funct3
        issue_store(3'd1, funct3_sw, 12'h002, 32'h0000_6000, 32'h6666_6666);  // word at ...2
        retire_check(3'd0);
        retire_check(3'd1);
        report_test("faults", start);
    endtask

    initial begin
        reset                = 1'b1;
        num_store_dispatched = 2'd0;
        issue_valid          = 1'b0;
        issue_index          = 3'd0;
        issue_inst           = '0;
        issue_base           = '0;
        issue_value          = '0;
        branch_recover       = 1'b0;
        recover_tail         = 3'd0;
        retire_store         = 1'b0;
        dmem_store_done      = 1'b0;
        reset_state();
        in_order_stores();
        out_of_order_issue();
        queue_capacity();
        branch_rollback();
        fault_stores();
        $display("checks passed %0d, errors %0d", passes, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- store_subsystem.f
lsq_pkg.sv
store_decode.sv
store_address_unit.sv
store_queue.sv
store_commit.sv
store_subsystem.sv
store_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= store_subsystem_tb
FILELIST  ?= store_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless the log reports a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
